//--- hw/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    //////////////////////////////////////////////////
    // timing
    //////////////////////////////////////////////////
    localparam int clks_per_usec  = 100;   // 100 MHz system clock
    localparam int scl_half_usec  = 5;     // 100 kHz scl
    localparam int stop_hold_usec = 3;
    localparam int tick_w         = $clog2(clks_per_usec);
    localparam int half_w         = $clog2(scl_half_usec);

    // PCF8574 style expander
    localparam logic [6:0] lcd_i2c_addr = 7'h27;

    // expander byte, nibble in 7:4
    localparam int lcd_bit_bl = 3;
    localparam int lcd_bit_en = 2;
    localparam int lcd_bit_rw = 1;
    localparam int lcd_bit_rs = 0;

    //////////////////////////////////////////////////
    // host register map
    //////////////////////////////////////////////////
    localparam int   wb_dw      = 16;
    localparam logic reg_data   = 1'b0;
    localparam logic reg_status = 1'b1;

    typedef enum logic [2:0] {
        seq_idle,
        seq_hi_off,
        seq_hi_on,
        seq_lo_on,
        seq_lo_off,
        seq_tail_off    // repeat of lo_off
    } seq_state_t;

    typedef enum logic [2:0] {
        i2c_idle,
        i2c_start,
        i2c_send_addr,
        i2c_addr_ack,
        i2c_send_data,
        i2c_data_ack,
        i2c_stop_low,
        i2c_stop
    } i2c_state_t;

endpackage

`default_nettype wire

//--- hw/wb_lcd_regs.sv
`timescale 1ns/1ns
`default_nettype none

module wb_lcd_regs (
    input  logic                     clk,
    input  logic                     reset_p,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic                     wb_adr,
    input  logic [lcd_pkg::wb_dw-1:0] wb_wdata,
    output logic [lcd_pkg::wb_dw-1:0] wb_rdata,
    output logic                     wb_ack,
    input  logic                     busy,
    output logic                     send,
    output logic [7:0]               data_byte,
    output logic                     rs
);

    logic req;
    logic data_wr;

    // new request, not the one being acked right now
    assign req     = wb_cyc & wb_stb & ~wb_ack;
    assign data_wr = req & wb_we & (wb_adr == lcd_pkg::reg_data);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            wb_ack <= 1'b0;
            send   <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            send   <= 1'b0;
            if (data_wr) begin
                if (!busy) begin   // held off until sequencer is free
                    wb_ack <= 1'b1;
                    send   <= 1'b1;
                end
            end else if (req) begin
                wb_ack <= 1'b1;    // reads and status writes
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr && !busy) begin
            data_byte <= wb_wdata[7:0];
            rs        <= wb_wdata[8];
        end
        if (req && !wb_we) begin
            if (wb_adr == lcd_pkg::reg_status)
                wb_rdata <= {{(lcd_pkg::wb_dw - 1){1'b0}}, busy};
            else
                wb_rdata <= {{(lcd_pkg::wb_dw - 9){1'b0}}, rs, data_byte};
        end
    end

endmodule

`default_nettype wire

//--- hw/lcd_nibble_seq.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_nibble_seq (
    input  logic       clk,
    input  logic       reset_p,
    input  logic       send,
    input  logic [7:0] data_byte,
    input  logic       rs,
    output logic       busy,
    output logic       start,
    output logic [7:0] frame_byte,
    input  logic       done
);

    lcd_pkg::seq_state_t state;

    logic [7:0] byte_q;
    logic       rs_q;
    logic       issued;     // start already sent for this frame
    logic [3:0] nib;
    logic       en;

    function automatic logic [7:0] frame_of(input logic [3:0] n, input logic e,
                                            input logic r);
        logic [7:0] f;
        f                      = '0;
        f[7:4]                 = n;
        f[lcd_pkg::lcd_bit_bl] = 1'b1;   // backlight on
        f[lcd_pkg::lcd_bit_en] = e;
        f[lcd_pkg::lcd_bit_rw] = 1'b0;   // write only
        f[lcd_pkg::lcd_bit_rs] = r;
        return f;
    endfunction

    always_comb begin
        nib = byte_q[3:0];
        en  = 1'b0;
        case (state)
            lcd_pkg::seq_hi_off: nib = byte_q[7:4];
            lcd_pkg::seq_hi_on: begin
                nib = byte_q[7:4];
                en  = 1'b1;
            end
            lcd_pkg::seq_lo_on: en = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state  <= lcd_pkg::seq_idle;
            busy   <= 1'b0;
            start  <= 1'b0;
            issued <= 1'b0;
        end else begin
            start <= 1'b0;
            if (state == lcd_pkg::seq_idle) begin
                if (send) begin
                    state  <= lcd_pkg::seq_hi_off;
                    busy   <= 1'b1;
                    issued <= 1'b0;
                end
            end else if (!issued) begin
                start  <= 1'b1;
                issued <= 1'b1;
            end else if (done) begin
                issued <= 1'b0;
                case (state)
                    lcd_pkg::seq_hi_off: state <= lcd_pkg::seq_hi_on;
                    lcd_pkg::seq_hi_on:  state <= lcd_pkg::seq_lo_on;
                    lcd_pkg::seq_lo_on:  state <= lcd_pkg::seq_lo_off;
                    lcd_pkg::seq_lo_off: state <= lcd_pkg::seq_tail_off;
                    default: begin
                        state <= lcd_pkg::seq_idle;
                        busy  <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == lcd_pkg::seq_idle && send) begin
            byte_q <= data_byte;
            rs_q   <= rs;
        end
        if (state != lcd_pkg::seq_idle && !issued)
            frame_byte <= frame_of(nib, en, rs_q);
    end

endmodule

`default_nettype wire

//--- hw/i2c_tx.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_tx (
    input  logic       clk,
    input  logic       reset_p,
    input  logic       start,
    input  logic [7:0] frame_byte,
    output logic       scl,
    output logic       sda,
    output logic       done
);

    lcd_pkg::i2c_state_t state;

    logic [lcd_pkg::tick_w-1:0] tick_cnt;
    logic [lcd_pkg::half_w-1:0] half_cnt;
    logic                       tick;
    logic                       scl_en;
    logic                       toggle;
    logic                       scl_fall;   // one clock after scl went low
    logic                       scl_rise;   // one clock after scl went high
    logic [2:0]                 bit_cnt;
    logic [7:0]                 data_q;
    logic [7:0]                 addr_rw;

    assign addr_rw = {lcd_pkg::lcd_i2c_addr, 1'b0};   // write
    assign scl_en  = (state != lcd_pkg::i2c_idle) && (state != lcd_pkg::i2c_start);
    assign tick    = (tick_cnt == lcd_pkg::tick_w'(lcd_pkg::clks_per_usec - 1));
    assign toggle  = scl_en && tick &&
                     (half_cnt == lcd_pkg::half_w'(lcd_pkg::scl_half_usec - 1));

    //////////////////////////////////////////////////
    // usec tick and scl
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            tick_cnt <= '0;
            half_cnt <= '0;
            scl      <= 1'b1;
            scl_fall <= 1'b0;
            scl_rise <= 1'b0;
        end else begin
            scl_fall <= toggle & scl;
            scl_rise <= toggle & ~scl;
            if (!scl_en) begin
                tick_cnt <= '0;
                half_cnt <= '0;
                scl      <= 1'b1;
            end else begin
                tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
                if (toggle) begin
                    half_cnt <= '0;
                    scl      <= ~scl;
                end else if (tick) begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state   <= lcd_pkg::i2c_idle;
            sda     <= 1'b1;
            done    <= 1'b0;
            bit_cnt <= 3'd7;
        end else begin
            done <= 1'b0;
            case (state)
                lcd_pkg::i2c_idle: begin
                    sda <= 1'b1;
                    if (start)
                        state <= lcd_pkg::i2c_start;
                end
                lcd_pkg::i2c_start: begin
                    sda     <= 1'b0;   // scl still high here
                    bit_cnt <= 3'd7;
                    state   <= lcd_pkg::i2c_send_addr;
                end
                lcd_pkg::i2c_send_addr: begin
                    if (scl_fall)
                        sda <= addr_rw[bit_cnt];
                    if (scl_rise) begin
                        bit_cnt <= bit_cnt - 1'b1;   // wraps back to 7
                        if (bit_cnt == 3'd0)
                            state <= lcd_pkg::i2c_addr_ack;
                    end
                end
                lcd_pkg::i2c_addr_ack: begin
                    if (scl_fall)
                        sda <= 1'b1;   // released, ack ignored
                    if (scl_rise)
                        state <= lcd_pkg::i2c_send_data;
                end
                lcd_pkg::i2c_send_data: begin
                    if (scl_fall)
                        sda <= data_q[bit_cnt];
                    if (scl_rise) begin
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == 3'd0)
                            state <= lcd_pkg::i2c_data_ack;
                    end
                end
                lcd_pkg::i2c_data_ack: begin
                    if (scl_fall)
                        sda <= 1'b1;
                    if (scl_rise)
                        state <= lcd_pkg::i2c_stop_low;
                end
                lcd_pkg::i2c_stop_low: begin
                    if (scl_fall)
                        sda <= 1'b0;
                    if (scl_rise)
                        state <= lcd_pkg::i2c_stop;
                end
                default: begin
                    // hold sda low a few usec with scl high, then stop edge
                    if (tick && half_cnt == lcd_pkg::half_w'(lcd_pkg::stop_hold_usec - 1)) begin
                        sda   <= 1'b1;
                        done  <= 1'b1;
                        state <= lcd_pkg::i2c_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lcd_pkg::i2c_idle && start)
            data_q <= frame_byte;
    end

endmodule

`default_nettype wire

//--- hw/i2c_lcd_top.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_lcd_top (
    input  logic                     clk,
    input  logic                     reset_p,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic                     wb_adr,
    input  logic [lcd_pkg::wb_dw-1:0] wb_wdata,
    output logic [lcd_pkg::wb_dw-1:0] wb_rdata,
    output logic                     wb_ack,
    output logic                     scl,
    output logic                     sda
);

    logic       busy;
    logic       send;
    logic [7:0] data_byte;
    logic       rs;
    logic       start;
    logic [7:0] frame_byte;
    logic       done;

    wb_lcd_regs u_regs (
        .clk       (clk),
        .reset_p   (reset_p),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .busy      (busy),
        .send      (send),
        .data_byte (data_byte),
        .rs        (rs)
    );

    lcd_nibble_seq u_seq (
        .clk        (clk),
        .reset_p    (reset_p),
        .send       (send),
        .data_byte  (data_byte),
        .rs         (rs),
        .busy       (busy),
        .start      (start),
        .frame_byte (frame_byte),
        .done       (done)
    );

    i2c_tx u_i2c (
        .clk        (clk),
        .reset_p    (reset_p),
        .start      (start),
        .frame_byte (frame_byte),
        .scl        (scl),
        .sda        (sda),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- sim/i2c_lcd_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_lcd_asserts (
    input logic                clk,
    input logic                reset_p,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic                wb_ack,
    input logic                scl,
    input logic                sda,
    input logic                send,
    input logic                busy,
    input lcd_pkg::i2c_state_t i2c_state
);

    int fail_cnt = 0;   // read by the testbench

    ack_in_cycle: assert property (@(posedge clk) disable iff (reset_p)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            fail_cnt++;
            $error("wb_ack high outside a bus cycle");
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset_p)
        wb_ack |=> !wb_ack)
        else begin
            fail_cnt++;
            $error("wb_ack high for two cycles");
        end

    // sda may only move under a high scl for start and stop
    sda_stable: assert property (@(posedge clk) disable iff (reset_p)
        (scl && $past(scl) && (sda != $past(sda))) |->
        ($past(i2c_state) == lcd_pkg::i2c_start || $past(i2c_state) == lcd_pkg::i2c_stop))
        else begin
            fail_cnt++;
            $error("sda changed while scl was high");
        end

    idle_bus_high: assert property (@(posedge clk) disable iff (reset_p)
        (i2c_state == lcd_pkg::i2c_idle) |-> (scl && sda))
        else begin
            fail_cnt++;
            $error("bus not released while the master is idle");
        end

    send_when_free: assert property (@(posedge clk) disable iff (reset_p)
        send |-> !busy)
        else begin
            fail_cnt++;
            $error("send pulsed while the sequencer was busy");
        end

endmodule

bind i2c_lcd_top i2c_lcd_asserts u_asserts (
    .clk       (clk),
    .reset_p   (reset_p),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .scl       (scl),
    .sda       (sda),
    .send      (send),
    .busy      (busy),
    .i2c_state (u_i2c.state)
);

`default_nettype wire

//--- sim/tb_i2c_lcd.sv
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_lcd;

    logic        clk;
    logic        reset_p;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_adr;
    logic [15:0] wb_wdata;
    logic [15:0] wb_rdata;
    logic        wb_ack;
    logic        scl;
    logic        sda;

    int     errors    = 0;
    int     tests     = 0;
    logic   hung      = 1'b0;
    int     byte_clks = 1200 * lcd_pkg::clks_per_usec;   // one LCD byte plus margin
    integer seed      = 32'ha431795e;
    event   run_over;

    // bus monitor
    logic       prev_scl = 1'b1;
    logic       prev_sda = 1'b1;
    logic       in_frame = 1'b0;
    logic [7:0] shift    = '0;
    int         bit_pos  = 0;
    int         stop_cnt = 0;
    int         bus_errs = 0;
    logic [7:0] rx_q[$];

    i2c_lcd_top UUT (
        .clk      (clk),
        .reset_p  (reset_p),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .scl      (scl),
        .sda      (sda)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // frame decode from scl/sda
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (scl && prev_scl && prev_sda && !sda) begin   // start
            if (in_frame)
                bus_errs++;
            in_frame = 1'b1;
            bit_pos  = 0;
        end else if (scl && prev_scl && !prev_sda && sda) begin   // stop
            if (!in_frame || bit_pos != 19)
                bus_errs++;
            else
                stop_cnt++;
            in_frame = 1'b0;
        end else if (scl && !prev_scl && in_frame) begin
            if ((bit_pos == 8 || bit_pos == 17) && !sda)   // ack slot left released
                bus_errs++;
            shift = {shift[6:0], sda};
            if (bit_pos == 7 || bit_pos == 16)   // last address bit or last data bit
                rx_q.push_back(shift);
            bit_pos++;
        end
        prev_scl = scl;
        prev_sda = sda;
    end

    function automatic logic [7:0] expected_frame(input logic [7:0] b, input logic r,
                                                  input int idx);
        logic [3:0] nib;
        logic       en;
        nib = (idx < 2) ? b[7:4] : b[3:0];
        en  = (idx == 1 || idx == 2);
        return {nib, 1'b1, en, 1'b0, r};
    endfunction

    task automatic give_up(input string why);
        $display("%s", why);
        hung = 1'b1;
        -> run_over;
        forever @(posedge clk);
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp)
        else begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic wb_write(input logic adr, input logic [15:0] data, output int waited);
        int n;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_wdata = data;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 2 * byte_clks)
                give_up("timeout: a write to the LCD port was never acknowledged");
        end while (!wb_ack);
        waited = n;
        @(posedge clk);   // ack cycle ends here
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic adr, output logic [15:0] data);
        int n;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 2 * byte_clks)
                give_up("timeout: a register read was never acknowledged");
        end while (!wb_ack);
        data = wb_rdata;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int n_clk;
        n_clk = 0;
        while (stop_cnt < n) begin
            @(posedge clk);
            #1;
            n_clk++;
            if (n_clk > 2 * byte_clks)
                give_up("timeout: the expected I2C frames never finished");
        end
    endtask

    // five frames of one LCD byte off the front of the queue
    task automatic check_group(input string name, input logic [7:0] b, input logic r);
        logic [7:0] got;
        assert (rx_q.size() >= 10)
        else begin
            errors++;
            $display("%s: fewer than five frames were decoded", name);
        end
        for (int i = 0; i < 5; i++) begin
            if (rx_q.size() >= 2) begin
                got = rx_q.pop_front();
                check_value($sformatf("%s frame %0d address", name, i),
                            16'({lcd_pkg::lcd_i2c_addr, 1'b0}), 16'(got));
                got = rx_q.pop_front();
                check_value($sformatf("%s frame %0d data", name, i),
                            16'(expected_frame(b, r, i)), 16'(got));
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("%-14s %s", name, (errors == errs_before) ? "passed" : "failed");
    endtask

    initial begin
        logic [15:0] rd;
        int          waited;
        int          base;
        int          mark;
        logic [7:0]  bytes[8];
        logic        rss[8];

        reset_p  = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 1'b0;
        wb_wdata = '0;
        repeat (5) @(posedge clk);
        #1 reset_p = 1'b0;

        mark = errors;
        check_value("reset_idle scl", 16'h1, 16'(scl));
        check_value("reset_idle sda", 16'h1, 16'(sda));
        wb_read(lcd_pkg::reg_status, rd);
        check_value("reset_idle status", 16'h0, rd);
        end_test("reset_idle", mark);

        mark = errors;
        base = stop_cnt;
        wb_write(lcd_pkg::reg_data, 16'h0141, waited);
        wb_read(lcd_pkg::reg_status, rd);
        check_value("busy_status after write", 16'h1, rd);
        wait_frames(base + 5);
        wb_read(lcd_pkg::reg_status, rd);
        check_value("busy_status after stop", 16'h0, rd);
        end_test("busy_status", mark);

        mark = errors;
        check_value("single_byte byte count", 16'd10, 16'(rx_q.size()));
        check_value("single_byte bus errors", 16'd0, 16'(bus_errs));
        check_group("single_byte", 8'h41, 1'b1);
        end_test("single_byte", mark);

        ////////////////////////////////////////////////
        // second write lands while the first is sent
        ////////////////////////////////////////////////
        mark = errors;
        base = stop_cnt;
        wb_write(lcd_pkg::reg_data, 16'h0028, waited);
        wb_write(lcd_pkg::reg_data, 16'h01c3, waited);
        check_value("back_pressure frames before ack", 16'd5, 16'(stop_cnt - base));
        assert (waited > 2)
        else begin
            errors++;
            $display("back_pressure: the second write was acknowledged while busy");
        end
        wait_frames(base + 10);
        check_value("back_pressure bus errors", 16'd0, 16'(bus_errs));
        check_group("back_pressure first", 8'h28, 1'b0);
        check_group("back_pressure second", 8'hc3, 1'b1);
        check_value("back_pressure leftover bytes", 16'd0, 16'(rx_q.size()));
        end_test("back_pressure", mark);

        mark = errors;
        base = stop_cnt;
        for (int i = 0; i < 8; i++) begin
            bytes[i] = 8'($random(seed));
            rss[i]   = 1'($random(seed));
            wb_write(lcd_pkg::reg_data, {7'b0, rss[i], bytes[i]}, waited);
        end
        wait_frames(base + 40);
        for (int i = 0; i < 8; i++)
            check_group($sformatf("random_bytes %0d", i), bytes[i], rss[i]);
        check_value("random_bytes bus errors", 16'd0, 16'(bus_errs));
        end_test("random_bytes", mark);

        mark = errors;
        wb_read(lcd_pkg::reg_data, rd);
        check_value("readback", {7'b0, rss[7], bytes[7]}, rd);
        end_test("readback", mark);

        -> run_over;
    end

    initial begin
        @(run_over);
        $display("%0d tests, %0d errors, %0d assertion failures",
                 tests, errors, UUT.u_asserts.fail_cnt);
        if (errors == 0 && !hung && UUT.u_asserts.fail_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/lcd_pkg.sv
hw/wb_lcd_regs.sv
hw/lcd_nibble_seq.sv
hw/i2c_tx.sv
hw/i2c_lcd_top.sv
sim/i2c_lcd_asserts.sv
sim/tb_i2c_lcd.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_i2c_lcd -f list.f -o tb_i2c_lcd
	./obj_dir/tb_i2c_lcd > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
